//--- dv/mem_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     s_ready,
  input logic                     m_valid,
  input logic                     m_ready,
  input mem_stage_pkg::mem_wb_t   wb_out,
  input mem_stage_pkg::dmem_req_t dmem_req
);

  import mem_stage_pkg::*;

  // Failed assertions, read by the testbench
  int fail_count = 0;

  // Stalled output must not move
  assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(wb_out)))
    else begin
      fail_count++;
      $error("Output changed while stalled");
    end

  // No memory access without ready
  assert property (@(posedge clk) disable iff (!rst_n)
    !s_ready |-> (!dmem_req.ren && !dmem_req.we))
    else begin
      fail_count++;
      $error("Memory strobe raised while not ready");
    end

endmodule

`default_nettype wire

//--- dv/mem_stage_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_monitor (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mem_stage_pkg::ex_mem_t    ex_in,
  input  logic [1:0]                kind,
  input  rv_isa_pkg::word_t         exp_value,
  input  rv_isa_pkg::strb_t         exp_strb,
  input  logic                      exp_trap,
  input  rv_isa_pkg::trap_code_t    exp_code,
  input  logic                      s_valid,
  input  logic                      s_ready,
  input  mem_stage_pkg::dmem_req_t  dmem_req,
  input  logic                      m_valid,
  input  logic                      m_ready,
  input  mem_stage_pkg::mem_wb_t    wb_out,
  input  rv_isa_pkg::word_t         result_mem,
  input  rv_isa_pkg::word_t         load_data_mem,
  output int                        error_count,
  output int                        pending
);

  import rv_isa_pkg::*;
  import mem_stage_pkg::*;

  // Kind codes of the stimulus table
  localparam logic [1:0] kind_load  = 2'd1;
  localparam logic [1:0] kind_store = 2'd2;

  mem_wb_t wb_q[$];
  bit      ld_chk_q[$];
  int      accepted = 0;
  int      retired = 0;

  initial error_count = 0;

  assign pending = wb_q.size();

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_accept();
    mem_wb_t exp_wb;
    logic    is_ld;
    logic    is_st;
    is_ld = (kind == kind_load);
    is_st = (kind == kind_store);
    check_value("dmem_req.ren", 32'(dmem_req.ren), 32'(is_ld && !exp_trap));
    check_value("dmem_req.we", 32'(dmem_req.we), 32'(is_st && !exp_trap));
    if (is_ld && !exp_trap) begin
      check_value("dmem_req.raddr", dmem_req.raddr, {ex_in.alu_result[31:2], 2'b00});
      check_value("load_data_mem", load_data_mem, exp_value);
    end
    if (is_st && !exp_trap) begin
      check_value("dmem_req.waddr", dmem_req.waddr, {ex_in.alu_result[31:2], 2'b00});
      check_value("dmem_req.wdata", dmem_req.wdata, exp_value);
    end
    // Strobes stay zero for anything but a store
    if (!is_st || !exp_trap) begin
      check_value("dmem_req.wstrb", 32'(dmem_req.wstrb), 32'(exp_strb));
    end
    if (kind == 2'd0) begin
      check_value("result_mem", result_mem, exp_value);
    end
    // Writeback copy expected one clock later
    exp_wb.reg_write  = ex_in.reg_write && !exp_trap;
    exp_wb.res_src    = ex_in.res_src;
    exp_wb.rd         = ex_in.rd;
    exp_wb.funct3     = ex_in.funct3;
    exp_wb.alu_result = ex_in.alu_result;
    exp_wb.ld_data    = exp_value;
    exp_wb.pc_plus4   = ex_in.pc_plus4;
    exp_wb.jb_target  = ex_in.jb_target;
    exp_wb.m_result   = ex_in.m_result;
    exp_wb.trap       = exp_trap;
    exp_wb.trap_code  = exp_code;
    wb_q.push_back(exp_wb);
    ld_chk_q.push_back(is_ld && !exp_trap);
    accepted++;
  endtask

  task automatic check_retire();
    mem_wb_t exp_wb;
    bit      ld_chk;
    exp_wb = wb_q.pop_front();
    ld_chk = ld_chk_q.pop_front();
    check_value("wb_out.reg_write", 32'(wb_out.reg_write), 32'(exp_wb.reg_write));
    check_value("wb_out.res_src", 32'(wb_out.res_src), 32'(exp_wb.res_src));
    check_value("wb_out.rd", 32'(wb_out.rd), 32'(exp_wb.rd));
    check_value("wb_out.funct3", 32'(wb_out.funct3), 32'(exp_wb.funct3));
    check_value("wb_out.alu_result", wb_out.alu_result, exp_wb.alu_result);
    check_value("wb_out.pc_plus4", wb_out.pc_plus4, exp_wb.pc_plus4);
    check_value("wb_out.jb_target", wb_out.jb_target, exp_wb.jb_target);
    check_value("wb_out.m_result", wb_out.m_result, exp_wb.m_result);
    check_value("wb_out.trap", 32'(wb_out.trap), 32'(exp_wb.trap));
    check_value("wb_out.trap_code", 32'(wb_out.trap_code), 32'(exp_wb.trap_code));
    // Load data only meaningful for a good load
    if (ld_chk) begin
      check_value("wb_out.ld_data", wb_out.ld_data, exp_wb.ld_data);
    end
    retired++;
  endtask

  // Sample mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (!rst_n) begin
      check_value("m_valid", 32'(m_valid), 32'd0);
      check_value("dmem_req.ren", 32'(dmem_req.ren), 32'd0);
      check_value("dmem_req.we", 32'(dmem_req.we), 32'd0);
    end else begin
      check_value("s_ready", 32'(s_ready), 32'(m_ready));
      // Retire first since the item accepted now shows up next cycle
      if (m_valid && m_ready) begin
        if (wb_q.size() == 0) begin
          error_count++;
          $display("Writeback output valid with no accepted item pending");
        end else begin
          check_retire();
        end
      end
      if (s_valid && s_ready) begin
        check_accept();
      end else begin
        check_value("dmem_req.ren", 32'(dmem_req.ren), 32'd0);
        check_value("dmem_req.we", 32'(dmem_req.we), 32'd0);
      end
    end
  end

  task automatic print_counts(input int assert_fails);
    $display("Accepted %0d, retired %0d, value errors %0d, assertion failures %0d",
             accepted, retired, error_count, assert_fails);
  endtask

endmodule

`default_nettype wire

//--- dv/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

  import rv_isa_pkg::*;
  import mem_stage_pkg::*;

  // One row of the stimulus table
  typedef struct packed {
    logic [1:0] kind;
    funct3_t    funct3;
    word_t      addr;
    word_t      st_data;
    word_t      mem_word;
    res_src_t   res_src;
    logic       trap_in;
    trap_code_t trap_code;
    word_t      exp_value;
    strb_t      exp_strb;
    logic       exp_trap;
    trap_code_t exp_code;
  } vector_t;

  localparam word_t mem_w = 32'h80F1_7F92;
  localparam word_t st_w  = 32'hA5C3_5A3C;

  logic       clk;
  logic       rst_n;
  ex_mem_t    ex_in;
  logic       s_valid;
  logic       s_ready;
  dmem_req_t  dmem_req;
  word_t      dmem_rdata;
  logic       m_valid;
  logic       m_ready;
  mem_wb_t    wb_out;
  word_t      result_mem;
  word_t      load_data_mem;
  logic [1:0] kind;
  word_t      exp_value;
  strb_t      exp_strb;
  logic       exp_trap;
  trap_code_t exp_code;
  int         error_count;
  int         pending;
  int         seed;
  vector_t    table_q[$];
  bit         timed_out;

  mem_stage UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_in         (ex_in),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .dmem_req      (dmem_req),
    .dmem_rdata    (dmem_rdata),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .wb_out        (wb_out),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem)
  );

  mem_stage_monitor u_monitor (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_in         (ex_in),
    .kind          (kind),
    .exp_value     (exp_value),
    .exp_strb      (exp_strb),
    .exp_trap      (exp_trap),
    .exp_code      (exp_code),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .dmem_req      (dmem_req),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .wb_out        (wb_out),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .error_count   (error_count),
    .pending       (pending)
  );

  bind mem_stage mem_stage_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_ready  (s_ready),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .wb_out   (wb_out),
    .dmem_req (dmem_req)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_row(input logic [1:0] k, input funct3_t f3, input word_t addr,
                         input res_src_t rs, input logic tr, input trap_code_t tc,
                         input word_t ev, input strb_t es, input logic et,
                         input trap_code_t ec);
    vector_t v;
    v.kind = k;
    v.funct3 = f3;
    v.addr = addr;
    v.st_data = st_w;
    v.mem_word = mem_w;
    v.res_src = rs;
    v.trap_in = tr;
    v.trap_code = tc;
    v.exp_value = ev;
    v.exp_strb = es;
    v.exp_trap = et;
    v.exp_code = ec;
    table_q.push_back(v);
  endtask

  task automatic build_table();
    // Signed and unsigned byte loads at each offset
    add_row(2'd1, 3'd0, 32'h100, 3'd0, 1'b0, 2'd0, 32'hFFFF_FF92, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd0, 32'h101, 3'd0, 1'b0, 2'd0, 32'h0000_007F, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd0, 32'h102, 3'd0, 1'b0, 2'd0, 32'hFFFF_FFF1, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd0, 32'h103, 3'd0, 1'b0, 2'd0, 32'hFFFF_FF80, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd4, 32'h100, 3'd0, 1'b0, 2'd0, 32'h0000_0092, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd4, 32'h101, 3'd0, 1'b0, 2'd0, 32'h0000_007F, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd4, 32'h102, 3'd0, 1'b0, 2'd0, 32'h0000_00F1, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd4, 32'h103, 3'd0, 1'b0, 2'd0, 32'h0000_0080, 4'h0, 1'b0, 2'd0);
    // Halfword and word loads
    add_row(2'd1, 3'd1, 32'h100, 3'd0, 1'b0, 2'd0, 32'h0000_7F92, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd1, 32'h102, 3'd0, 1'b0, 2'd0, 32'hFFFF_80F1, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd5, 32'h100, 3'd0, 1'b0, 2'd0, 32'h0000_7F92, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd5, 32'h102, 3'd0, 1'b0, 2'd0, 32'h0000_80F1, 4'h0, 1'b0, 2'd0);
    add_row(2'd1, 3'd2, 32'h100, 3'd0, 1'b0, 2'd0, 32'h80F1_7F92, 4'h0, 1'b0, 2'd0);
    // Stores with data replicated over the lanes
    add_row(2'd2, 3'd0, 32'h200, 3'd0, 1'b0, 2'd0, 32'h3C3C_3C3C, 4'h1, 1'b0, 2'd0);
    add_row(2'd2, 3'd0, 32'h201, 3'd0, 1'b0, 2'd0, 32'h3C3C_3C3C, 4'h2, 1'b0, 2'd0);
    add_row(2'd2, 3'd0, 32'h202, 3'd0, 1'b0, 2'd0, 32'h3C3C_3C3C, 4'h4, 1'b0, 2'd0);
    add_row(2'd2, 3'd0, 32'h203, 3'd0, 1'b0, 2'd0, 32'h3C3C_3C3C, 4'h8, 1'b0, 2'd0);
    add_row(2'd2, 3'd1, 32'h200, 3'd0, 1'b0, 2'd0, 32'h5A3C_5A3C, 4'h3, 1'b0, 2'd0);
    add_row(2'd2, 3'd1, 32'h202, 3'd0, 1'b0, 2'd0, 32'h5A3C_5A3C, 4'hC, 1'b0, 2'd0);
    add_row(2'd2, 3'd2, 32'h200, 3'd0, 1'b0, 2'd0, 32'hA5C3_5A3C, 4'hF, 1'b0, 2'd0);
    // Misaligned accesses trap
    add_row(2'd1, 3'd1, 32'h101, 3'd0, 1'b0, 2'd0, 32'h0, 4'h0, 1'b1, 2'd2);
    add_row(2'd1, 3'd2, 32'h102, 3'd0, 1'b0, 2'd0, 32'h0, 4'h0, 1'b1, 2'd2);
    add_row(2'd2, 3'd1, 32'h203, 3'd0, 1'b0, 2'd0, 32'h0, 4'h0, 1'b1, 2'd2);
    add_row(2'd2, 3'd2, 32'h201, 3'd0, 1'b0, 2'd0, 32'h0, 4'h0, 1'b1, 2'd2);
    // Incoming traps keep their code
    add_row(2'd1, 3'd2, 32'h100, 3'd0, 1'b1, 2'd3, 32'h0, 4'h0, 1'b1, 2'd3);
    add_row(2'd0, 3'd0, 32'h055, 3'd0, 1'b1, 2'd1, 32'h0000_0055, 4'h0, 1'b1, 2'd1);
    // Forwarding sources
    add_row(2'd0, 3'd0, 32'h1234, 3'd0, 1'b0, 2'd0, 32'h0000_1234, 4'h0, 1'b0, 2'd0);
    add_row(2'd0, 3'd0, 32'h1234, 3'd1, 1'b0, 2'd0, 32'h0BAD_F00D, 4'h0, 1'b0, 2'd0);
    add_row(2'd0, 3'd0, 32'h1234, 3'd2, 1'b0, 2'd0, 32'h0000_1004, 4'h0, 1'b0, 2'd0);
    add_row(2'd0, 3'd0, 32'h1234, 3'd3, 1'b0, 2'd0, 32'h0000_2200, 4'h0, 1'b0, 2'd0);
  endtask

  task automatic drive_row(input vector_t v, input int idx);
    ex_in.reg_write  = (v.kind != 2'd2);
    ex_in.mem_read   = (v.kind == 2'd1);
    ex_in.mem_write  = (v.kind == 2'd2);
    ex_in.res_src    = v.res_src;
    ex_in.rd         = 5'(idx + 1);
    ex_in.funct3     = v.funct3;
    ex_in.alu_result = v.addr;
    ex_in.rs2_data   = v.st_data;
    ex_in.pc_plus4   = 32'h0000_1004;
    ex_in.jb_target  = 32'h0000_2200;
    ex_in.m_result   = 32'h0BAD_F00D;
    ex_in.trap       = v.trap_in;
    ex_in.trap_code  = v.trap_code;
    // Combinational SRAM model returns the entry's word
    dmem_rdata = v.mem_word;
    kind       = v.kind;
    exp_value  = v.exp_value;
    exp_strb   = v.exp_strb;
    exp_trap   = v.exp_trap;
    exp_code   = v.exp_code;
  endtask

  initial begin
    int tries;
    int checker_fails;
    bit taken;
    seed = 32'heed1_f4c5;
    timed_out = 1'b0;
    rst_n = 1'b0;
    s_valid = 1'b0;
    m_ready = 1'b1;
    ex_in = '0;
    dmem_rdata = '0;
    kind = 2'd0;
    exp_value = '0;
    exp_strb = '0;
    exp_trap = 1'b0;
    exp_code = '0;
    build_table();

    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    // Idle cycles after reset with the stage empty
    repeat (2) @(posedge clk);
    #2;

    foreach (table_q[i]) begin
      if (!timed_out) begin
        drive_row(table_q[i], i);
        s_valid = 1'b1;
        // Random back-pressure on roughly one cycle in four
        m_ready = (($random(seed) & 3) != 0);
        taken = 1'b0;
        tries = 0;
        // Entry is taken at the edge that sees s_ready high
        while (!taken && tries < 40) begin
          @(posedge clk);
          taken = s_ready;
          #2;
          if (!taken) begin
            m_ready = (($random(seed) & 3) != 0);
          end
          tries++;
        end
        if (!taken) begin
          timed_out = 1'b1;
          $display("Timeout waiting for the stage to accept entry %0d", i);
        end
      end
    end

    // Drain the last item into writeback
    s_valid = 1'b0;
    m_ready = 1'b1;
    tries = 0;
    while ((m_valid || pending != 0) && tries < 40) begin
      @(posedge clk);
      #2 tries++;
    end
    if (m_valid || pending != 0) begin
      timed_out = 1'b1;
      $display("Timeout waiting for the writeback output to drain");
    end

    checker_fails = UUT.u_checker.fail_count;
    u_monitor.print_counts(checker_fails);
    if (!timed_out && error_count == 0 && checker_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Overall limit on simulated time
  initial begin
    #200000;
    $display("Timeout on total simulation time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- include/mem_stage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data and address width of the stage
`define MEM_XLEN 32

// Destination register index width
`define MEM_RD_BITS 5

// One strobe bit per byte lane
`define MEM_STRB_BITS 4

`endif

//--- mem_stage.f
+incdir+include
verilog/rv_isa_pkg.sv
verilog/mem_stage_pkg.sv
verilog/store_formatter.sv
verilog/load_formatter.sv
verilog/ldst_align_check.sv
verilog/mem_wb_register.sv
verilog/mem_stage.sv
dv/mem_stage_checker.sv
dv/mem_stage_monitor.sv
dv/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_stage testbench with Verilator

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f mem_stage.f --top-module mem_stage_tb \
  -o mem_stage_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/mem_stage_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Test failed" sim.log && exit 1 || grep -q "Test passed" sim.log || exit 1
exit 0

//--- verilog/ldst_align_check.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_align_check (
  input  logic                   mem_read,
  input  logic                   mem_write,
  input  rv_isa_pkg::funct3_t    funct3,
  input  logic [1:0]             offset,
  input  logic                   trap_in,
  input  rv_isa_pkg::trap_code_t trap_code_in,
  output logic                   misalign,
  output logic                   trap_out,
  output rv_isa_pkg::trap_code_t trap_code_out
);

  import rv_isa_pkg::*;

  logic mem_access;

  assign mem_access = mem_read || mem_write;

  always_comb begin
    misalign = 1'b0;

    // Only loads and stores can be misaligned
    if (mem_access) begin
      case (funct3[1:0])
        // Halfword needs an even address
        size_half: misalign = offset[0];
        // Word needs both low bits clear
        size_word: misalign = |offset;
        default:   misalign = 1'b0;
      endcase
    end
  end

  // Merge with a trap from an earlier stage
  assign trap_out = trap_in || misalign;

  // Misalignment code wins over the incoming one
  assign trap_code_out = misalign ? trap_ldst_misalign : trap_code_in;

endmodule

`default_nettype wire

//--- verilog/load_formatter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_settings.svh"

module load_formatter (
  input  rv_isa_pkg::word_t   data_in,
  input  logic [1:0]          offset,
  input  rv_isa_pkg::funct3_t funct3,
  output rv_isa_pkg::word_t   data_out
);

  import rv_isa_pkg::*;

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        unsigned_ld;

  // Bit 2 of funct3 marks LBU and LHU
  assign unsigned_ld = funct3[2];

  // Byte lane picked by both offset bits
  always_comb begin
    case (offset)
      2'd0:    ld_byte = data_in[7:0];
      2'd1:    ld_byte = data_in[15:8];
      2'd2:    ld_byte = data_in[23:16];
      default: ld_byte = data_in[31:24];
    endcase
  end

  // Halfword picked by offset bit 1 only
  assign ld_half = offset[1] ? data_in[31:16] : data_in[15:0];

  always_comb begin
    case (funct3[1:0])
      size_byte: begin
        if (unsigned_ld) begin
          data_out = {{(`MEM_XLEN - 8){1'b0}}, ld_byte};
        end else begin
          data_out = {{(`MEM_XLEN - 8){ld_byte[7]}}, ld_byte};
        end
      end

      size_half: begin
        if (unsigned_ld) begin
          data_out = {{(`MEM_XLEN - 16){1'b0}}, ld_half};
        end else begin
          data_out = {{(`MEM_XLEN - 16){ld_half[15]}}, ld_half};
        end
      end

      // Full word, nothing to extend
      default: begin
        data_out = data_in;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mem_stage_pkg::ex_mem_t    ex_in,
  input  logic                      s_valid,
  output logic                      s_ready,
  output mem_stage_pkg::dmem_req_t  dmem_req,
  input  rv_isa_pkg::word_t         dmem_rdata,
  output logic                      m_valid,
  input  logic                      m_ready,
  output mem_stage_pkg::mem_wb_t    wb_out,
  output rv_isa_pkg::word_t         result_mem,
  output rv_isa_pkg::word_t         load_data_mem
);

  import rv_isa_pkg::*;

  logic       s_accept;
  logic [1:0] offset;
  logic       mem_ok;
  word_t      word_addr;
  word_t      st_data;
  strb_t      st_strb;
  word_t      ld_data;
  logic       misalign;
  logic       trap_any;
  trap_code_t trap_code_any;

  // No internal buffering, so ready comes straight from writeback
  assign s_ready  = m_ready;
  assign s_accept = s_valid && s_ready;

  // Byte position inside the addressed word
  assign offset = ex_in.alu_result[1:0];

  // Memory sees word addresses, lanes come from the strobes
  assign word_addr = ex_in.alu_result & ~word_t'(3);

  ldst_align_check u_align (
    .mem_read      (ex_in.mem_read),
    .mem_write     (ex_in.mem_write),
    .funct3        (ex_in.funct3),
    .offset        (offset),
    .trap_in       (ex_in.trap),
    .trap_code_in  (ex_in.trap_code),
    .misalign      (misalign),
    .trap_out      (trap_any),
    .trap_code_out (trap_code_any)
  );

  // Any trap suppresses the access
  assign mem_ok = !ex_in.trap && !misalign;

  // Store data comes from rs2, forwarded in execute
  store_formatter u_st_fmt (
    .data_in  (ex_in.rs2_data),
    .offset   (offset),
    .funct3   (ex_in.funct3),
    .data_out (st_data),
    .wstrb    (st_strb)
  );

  // Enables pulse for the accepting cycle only, so a stall never repeats an access
  assign dmem_req.ren   = s_accept && ex_in.mem_read && mem_ok;
  assign dmem_req.raddr = word_addr;
  assign dmem_req.we    = s_accept && ex_in.mem_write && mem_ok;
  assign dmem_req.waddr = word_addr;
  assign dmem_req.wdata = st_data;
  // Strobes stay quiet for anything but a store
  assign dmem_req.wstrb = ex_in.mem_write ? st_strb : '0;

  // Combinational SRAM, read data is formatted in this cycle
  load_formatter u_ld_fmt (
    .data_in  (dmem_rdata),
    .offset   (offset),
    .funct3   (ex_in.funct3),
    .data_out (ld_data)
  );

  assign load_data_mem = ld_data;

  // Forwarding result for instructions still in this stage
  always_comb begin
    case (ex_in.res_src)
      res_m:   result_mem = ex_in.m_result;
      res_pc4: result_mem = ex_in.pc_plus4;
      res_tgt: result_mem = ex_in.jb_target;
      // ALU result for res_alu and the rest
      default: result_mem = ex_in.alu_result;
    endcase
  end

  // One cycle into writeback
  mem_wb_register u_mem_wb (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .ex_in     (ex_in),
    .ld_data   (ld_data),
    .trap      (trap_any),
    .trap_code (trap_code_any),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .wb_out    (wb_out)
  );

endmodule

`default_nettype wire

//--- verilog/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  import rv_isa_pkg::*;

  // Instruction as handed over by execute
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    res_src_t   res_src;
    reg_idx_t   rd;
    funct3_t    funct3;
    // Also the byte address of loads and stores
    word_t      alu_result;
    // Store data, already forwarded in execute
    word_t      rs2_data;
    word_t      pc_plus4;
    word_t      jb_target;
    word_t      m_result;
    // Trap raised by an earlier stage
    logic       trap;
    trap_code_t trap_code;
  } ex_mem_t;

  // Data memory request, addresses are word aligned
  typedef struct packed {
    logic  ren;
    word_t raddr;
    logic  we;
    word_t waddr;
    // Store data replicated over the lanes
    word_t wdata;
    strb_t wstrb;
  } dmem_req_t;

  // Registered payload towards writeback
  typedef struct packed {
    logic       reg_write;
    res_src_t   res_src;
    reg_idx_t   rd;
    funct3_t    funct3;
    word_t      alu_result;
    // Formatted load result
    word_t      ld_data;
    word_t      pc_plus4;
    word_t      jb_target;
    word_t      m_result;
    logic       trap;
    trap_code_t trap_code;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/mem_wb_register.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_register (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     s_valid,
  input  mem_stage_pkg::ex_mem_t   ex_in,
  input  rv_isa_pkg::word_t        ld_data,
  input  logic                     trap,
  input  rv_isa_pkg::trap_code_t   trap_code,
  input  logic                     m_ready,
  output logic                     m_valid,
  output mem_stage_pkg::mem_wb_t   wb_out
);

  import mem_stage_pkg::*;

  logic    load_en;
  mem_wb_t wb_next;

  // Register is free when empty or being drained by writeback
  assign load_en = !m_valid || m_ready;

  always_comb begin
    // A trapping instruction must not write the register file
    wb_next.reg_write  = ex_in.reg_write && !trap;
    wb_next.res_src    = ex_in.res_src;
    wb_next.rd         = ex_in.rd;
    wb_next.funct3     = ex_in.funct3;
    wb_next.alu_result = ex_in.alu_result;
    // Already formatted, SRAM data arrives in the same cycle
    wb_next.ld_data    = ld_data;
    wb_next.pc_plus4   = ex_in.pc_plus4;
    wb_next.jb_target  = ex_in.jb_target;
    wb_next.m_result   = ex_in.m_result;
    wb_next.trap       = trap;
    wb_next.trap_code  = trap_code;
  end

  // Valid bit follows s_valid whenever the register loads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (load_en) begin
      m_valid <= s_valid;
    end
  end

  // Payload holds while stalled
  always_ff @(posedge clk) begin
    if (load_en) begin
      wb_out <= wb_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv_isa_pkg.sv
`default_nettype none

`include "mem_stage_settings.svh"

package rv_isa_pkg;

  // One data or address word
  typedef logic [`MEM_XLEN-1:0] word_t;

  // Byte lane strobes of one word
  typedef logic [`MEM_STRB_BITS-1:0] strb_t;

  // Destination register number
  typedef logic [`MEM_RD_BITS-1:0] reg_idx_t;

  // Access size in bits 1:0, unsigned load flag in bit 2
  typedef logic [2:0] funct3_t;

  // Writeback result source
  typedef logic [2:0] res_src_t;

  // Trap cause carried down the pipe
  typedef logic [1:0] trap_code_t;

  // Result source codes
  localparam res_src_t res_alu = 3'd0;
  localparam res_src_t res_m   = 3'd1;
  localparam res_src_t res_pc4 = 3'd2;
  localparam res_src_t res_tgt = 3'd3;

  // Load or store address not aligned to its size
  localparam trap_code_t trap_ldst_misalign = 2'd2;

  // Access size codes in funct3[1:0]
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

endpackage

`default_nettype wire

//--- verilog/store_formatter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_settings.svh"

module store_formatter (
  input  rv_isa_pkg::word_t   data_in,
  input  logic [1:0]          offset,
  input  rv_isa_pkg::funct3_t funct3,
  output rv_isa_pkg::word_t   data_out,
  output rv_isa_pkg::strb_t   wstrb
);

  import rv_isa_pkg::*;

  // Single lane and lane pair patterns before shifting to the offset
  localparam strb_t strb_one  = strb_t'(1);
  localparam strb_t strb_pair = strb_t'(3);

  always_comb begin
    // Word store is the fallback
    data_out = data_in;
    wstrb    = '1;

    case (funct3[1:0])
      size_byte: begin
        // Low byte copied into every lane
        data_out = {`MEM_STRB_BITS{data_in[7:0]}};
        wstrb    = strb_one << offset;
      end

      size_half: begin
        // Low half copied into both halves
        data_out = {(`MEM_STRB_BITS / 2){data_in[15:0]}};
        // Two lanes starting at the offset
        wstrb    = strb_pair << offset;
      end

      default: begin
        data_out = data_in;
        wstrb    = '1;
      end
    endcase
  end

endmodule

`default_nettype wire
